/* lc4_cfg.svh */
`ifndef LC4_CFG_SVH
`define LC4_CFG_SVH

// datapath and instruction width
`define LC4_WORD 16

// architectural registers r0..r7
`define LC4_NREGS 8
`define LC4_RSEL_W $clog2(`LC4_NREGS)

// issue width of the pipe
`define LC4_LANES 2

// first fetch address out of reset
`define LC4_RESET_PC 16'h8200

// stall codes seen on the test outputs
`define LC4_STALL_ISSUED 2'd0
`define LC4_STALL_SPLIT  2'd1
`define LC4_STALL_RESET  2'd2

`endif

/* lc4_isa_pkg.sv */
`include "lc4_cfg.svh"

package lc4_isa_pkg;

    // major opcodes, only the kept ones are named
    typedef enum logic [3:0] {
        OP_NOP   = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_LOGIC = 4'b0101,
        OP_CONST = 4'b1001
    } lc4_opcode_e;

    // arith sub-ops in insn[4:3]
    typedef enum logic [1:0] {
        ARITH_ADD = 2'b00,
        ARITH_MUL = 2'b01,
        ARITH_SUB = 2'b10,
        ARITH_DIV = 2'b11          // not supported here, retires as a nop
    } lc4_arith_sub_e;

    // logic sub-ops in insn[4:3]
    typedef enum logic [1:0] {
        LOGIC_AND = 2'b00,
        LOGIC_NOT = 2'b01,
        LOGIC_OR  = 2'b10,
        LOGIC_XOR = 2'b11
    } lc4_logic_sub_e;

    // register form, rd <= rs op rt
    typedef struct packed {
        lc4_opcode_e             opcode;
        logic [`LC4_RSEL_W-1:0]  rd;
        logic [`LC4_RSEL_W-1:0]  rs;
        logic                    imm_mode;   // 0 here
        logic [1:0]              sub;        // arith or logic sub-op
        logic [`LC4_RSEL_W-1:0]  rt;
    } lc4_rform_t;

    // immediate form, rd <= rs op sext(imm5)
    typedef struct packed {
        lc4_opcode_e             opcode;
        logic [`LC4_RSEL_W-1:0]  rd;
        logic [`LC4_RSEL_W-1:0]  rs;
        logic                    imm_mode;   // 1 here
        logic [4:0]              imm5;
    } lc4_iform_t;

    // the same word read two ways, picked by imm_mode
    typedef union packed {
        lc4_rform_t r;
        lc4_iform_t i;
    } lc4_insn_u;

    // condition flags, one-hot after any write
    typedef struct packed {
        logic n;
        logic z;
        logic p;
    } lc4_nzp_t;

endpackage

/* lc4_pipe_pkg.sv */
`include "lc4_cfg.svh"

package lc4_pipe_pkg;

    // x-stage function select
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_MUL,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOT,
        ALU_CONST                        // passes the immediate through
    } lc4_alu_e;

    typedef enum logic [1:0] {
        STALL_ISSUED = `LC4_STALL_ISSUED,
        STALL_SPLIT  = `LC4_STALL_SPLIT,
        STALL_RESET  = `LC4_STALL_RESET
    } lc4_stall_e;

    typedef struct packed {
        lc4_alu_e                alu;
        logic [`LC4_RSEL_W-1:0]  rs_sel;
        logic                    rs_re;
        logic [`LC4_RSEL_W-1:0]  rt_sel;
        logic                    rt_re;
        logic [`LC4_RSEL_W-1:0]  rd_sel;
        logic                    regfile_we;
        logic                    nzp_we;
        logic                    use_imm;
        logic [`LC4_WORD-1:0]    imm;     // already sign-extended
        logic [`LC4_WORD-1:0]    insn;    // raw word, carried to retire
    } lc4_op_t;

    // non-writing op that still carries its raw word
    function automatic lc4_op_t lc4_nop_op(input logic [`LC4_WORD-1:0] insn);
        lc4_op_t op;
        op      = '0;
        op.alu  = ALU_CONST;            // imm is 0, so result reads 0
        op.insn = insn;
        return op;
    endfunction

endpackage

/* lc4_ifaces.sv */
`include "lc4_cfg.svh"

// issue register of one lane, issue stage -> lane x stage
interface lc4_issue_if
    import lc4_pipe_pkg::*;
();
    logic [`LC4_WORD-1:0] pc;      // address of the word in this slot
    lc4_op_t              op;      // decoded op, nop on split or reset
    lc4_stall_e           stall;

    modport issuer (
        output pc,
        output op,
        output stall
    );

    modport lane (
        input pc,
        input op,
        input stall
    );
endinterface

// w register of one lane, lane -> regfile and test outputs
interface lc4_retire_if
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;
();
    logic [`LC4_WORD-1:0]   pc;
    logic [`LC4_WORD-1:0]   insn;
    logic                   regfile_we;
    logic [`LC4_RSEL_W-1:0] wsel;
    logic [`LC4_WORD-1:0]   data;
    logic                   nzp_we;
    lc4_nzp_t               nzp;
    lc4_stall_e             stall;

    modport lane (
        output pc, insn, regfile_we, wsel, data,
        output nzp_we, nzp, stall
    );

    // regfile only needs the write port fields
    modport drain (
        input regfile_we, wsel, data
    );
endinterface

/* lc4_decoder.sv */
`include "lc4_cfg.svh"

module lc4_decoder
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;
(
    input  lc4_insn_u i_insn,
    output lc4_op_t   o_op
);

    logic [8:0] imm9;                 // const field, low nine bits
    logic       writes;               // opcode/sub-op is one we execute

    assign imm9 = i_insn[8:0];

    always_comb begin
        o_op        = lc4_nop_op(i_insn);
        writes      = 1'b0;
        o_op.rd_sel = i_insn.r.rd;    // rd sits in the same place in every view
        o_op.rs_sel = i_insn.r.rs;
        o_op.rt_sel = i_insn.r.rt;
        case (i_insn.r.opcode)
            OP_ARITH, OP_LOGIC: begin
                o_op.rs_re = 1'b1;
                writes     = 1'b1;
                if (i_insn.i.imm_mode) begin            // i-form, ADD or AND only
                    o_op.use_imm = 1'b1;
                    o_op.imm     = {{(`LC4_WORD-5){i_insn.i.imm5[4]}}, i_insn.i.imm5};
                    o_op.alu     = (i_insn.i.opcode == OP_ARITH) ? ALU_ADD : ALU_AND;
                end else if (i_insn.r.opcode == OP_ARITH) begin
                    o_op.rt_re = 1'b1;
                    case (i_insn.r.sub)
                        ARITH_ADD: o_op.alu = ALU_ADD;
                        ARITH_MUL: o_op.alu = ALU_MUL;
                        ARITH_SUB: o_op.alu = ALU_SUB;
                        default:   writes   = 1'b0;    // div dropped
                    endcase
                end else begin
                    o_op.rt_re = (i_insn.r.sub != LOGIC_NOT);   // not is unary
                    case (i_insn.r.sub)
                        LOGIC_AND: o_op.alu = ALU_AND;
                        LOGIC_NOT: o_op.alu = ALU_NOT;
                        LOGIC_OR:  o_op.alu = ALU_OR;
                        default:   o_op.alu = ALU_XOR;
                    endcase
                end
            end
            OP_CONST: begin
                writes       = 1'b1;
                o_op.alu     = ALU_CONST;
                o_op.use_imm = 1'b1;
                o_op.imm     = {{(`LC4_WORD-9){imm9[8]}}, imm9};
            end
            default: ;                                 // everything else stays a nop
        endcase
        o_op.regfile_we = writes;
        o_op.nzp_we     = writes;
        if (!writes) o_op = lc4_nop_op(i_insn);        // drop read flags too, no false split
    end

endmodule

/* lc4_issue.sv */
`include "lc4_cfg.svh"

module lc4_issue
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;
(
    input  logic                 gwe,
    input  logic                 i_rst_n,
    input  lc4_insn_u            i_insn_a,      // word at o_pc
    input  lc4_insn_u            i_insn_b,      // word at o_pc + 1
    output logic [`LC4_WORD-1:0] o_pc,
    lc4_issue_if.issuer          o_issue [`LC4_LANES]
);

    logic [`LC4_WORD-1:0] pc_q;
    logic [`LC4_WORD-1:0] pc_b;      // pc of the second word
    logic [`LC4_WORD-1:0] pc_next;
    lc4_op_t              op_a;
    lc4_op_t              op_b;
    logic                 rs_hit;
    logic                 rt_hit;
    logic                 split;     // b depends on a, hold b back

    lc4_decoder dec_a_i (
        .i_insn (i_insn_a),
        .o_op   (op_a)
    );

    lc4_decoder dec_b_i (
        .i_insn (i_insn_b),
        .o_op   (op_b)
    );

    // intra-packet raw check, only b can depend on a
    assign rs_hit = op_b.rs_re && (op_b.rs_sel == op_a.rd_sel);
    assign rt_hit = op_b.rt_re && (op_b.rt_sel == op_a.rd_sel);
    assign split  = op_a.regfile_we && (rs_hit || rt_hit);

    assign pc_b    = pc_q + `LC4_WORD'd1;
    assign pc_next = split ? pc_b : pc_q + `LC4_WORD'd2;   // held word refetched as next a
    assign o_pc    = pc_q;

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            pc_q <= `LC4_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // issue registers, lane a
    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            o_issue[0].pc    <= '0;
            o_issue[0].op    <= lc4_nop_op('0);
            o_issue[0].stall <= STALL_RESET;
        end else begin
            o_issue[0].pc    <= pc_q;
            o_issue[0].op    <= op_a;              // a always goes
            o_issue[0].stall <= STALL_ISSUED;
        end
    end

    // issue registers, lane b
    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            o_issue[1].pc    <= '0;
            o_issue[1].op    <= lc4_nop_op('0);
            o_issue[1].stall <= STALL_RESET;
        end else begin
            o_issue[1].pc    <= pc_b;
            o_issue[1].op    <= split ? lc4_nop_op('0) : op_b;   // bubble on split
            o_issue[1].stall <= split ? STALL_SPLIT : STALL_ISSUED;
        end
    end

endmodule

/* lc4_lane.sv */
`include "lc4_cfg.svh"

module lc4_lane
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;
(
    input  logic                   gwe,
    input  logic                   i_rst_n,
    lc4_issue_if.lane              i_issue,
    output logic [`LC4_RSEL_W-1:0] o_rs_sel,
    output logic [`LC4_RSEL_W-1:0] o_rt_sel,
    input  logic [`LC4_WORD-1:0]   i_rs_data,   // already forwarded by the regfile
    input  logic [`LC4_WORD-1:0]   i_rt_data,
    lc4_retire_if.lane             o_retire
);

    lc4_op_t              op;
    logic [`LC4_WORD-1:0] opnd_b;     // rt or immediate
    logic [`LC4_WORD-1:0] result;
    lc4_nzp_t             nzp;

    assign op       = i_issue.op;
    assign o_rs_sel = op.rs_sel;
    assign o_rt_sel = op.rt_sel;
    assign opnd_b   = op.use_imm ? op.imm : i_rt_data;

    // x stage alu
    always_comb begin
        case (op.alu)
            ALU_ADD:   result = i_rs_data + opnd_b;
            ALU_SUB:   result = i_rs_data - opnd_b;
            ALU_MUL:   result = i_rs_data * opnd_b;    // low half kept
            ALU_AND:   result = i_rs_data & opnd_b;
            ALU_OR:    result = i_rs_data | opnd_b;
            ALU_XOR:   result = i_rs_data ^ opnd_b;
            ALU_NOT:   result = ~i_rs_data;
            default:   result = op.imm;                // const
        endcase
    end

    // flags from the signed result
    always_comb begin
        nzp = '0;
        if ($signed(result) > 0) begin
            nzp.p = 1'b1;
        end else if (result == '0) begin
            nzp.z = 1'b1;
        end else begin
            nzp.n = 1'b1;
        end
    end

    // w register, visible on the test outputs
    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            o_retire.pc         <= '0;
            o_retire.insn       <= '0;
            o_retire.regfile_we <= 1'b0;
            o_retire.wsel       <= '0;
            o_retire.data       <= '0;
            o_retire.nzp_we     <= 1'b0;
            o_retire.nzp        <= '0;
            o_retire.stall      <= STALL_RESET;
        end else begin
            o_retire.pc         <= i_issue.pc;
            o_retire.insn       <= op.insn;
            o_retire.regfile_we <= op.regfile_we;
            o_retire.wsel       <= op.rd_sel;
            o_retire.data       <= result;
            o_retire.nzp_we     <= op.nzp_we;
            o_retire.nzp        <= nzp;
            o_retire.stall      <= i_issue.stall;   // split/issued tag rides along
        end
    end

endmodule

/* lc4_regfile_ss.sv */
`include "lc4_cfg.svh"

module lc4_regfile_ss (
    input  logic                   gwe,
    input  logic                   i_rst_n,
    lc4_retire_if.drain            i_retire  [`LC4_LANES],
    input  logic [`LC4_RSEL_W-1:0] i_rs_sel  [`LC4_LANES],
    input  logic [`LC4_RSEL_W-1:0] i_rt_sel  [`LC4_LANES],
    output logic [`LC4_WORD-1:0]   o_rs_data [`LC4_LANES],
    output logic [`LC4_WORD-1:0]   o_rt_data [`LC4_LANES]
);

    logic [`LC4_WORD-1:0]   regs   [`LC4_NREGS];
    logic                   w_we   [`LC4_LANES];   // w-stage write ports
    logic [`LC4_RSEL_W-1:0] w_sel  [`LC4_LANES];
    logic [`LC4_WORD-1:0]   w_data [`LC4_LANES];

    for (genvar g = 0; g < `LC4_LANES; g++) begin : g_drain
        assign w_we[g]   = i_retire[g].regfile_we;
        assign w_sel[g]  = i_retire[g].wsel;
        assign w_data[g] = i_retire[g].data;
    end

    // higher lane writes last, so b wins on the same register
    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            for (int r = 0; r < `LC4_NREGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < `LC4_LANES; l++) begin
                if (w_we[l]) regs[w_sel[l]] <= w_data[l];
            end
        end
    end

    // write-through read ports, same lane order for priority
    for (genvar g = 0; g < `LC4_LANES; g++) begin : g_read
        always_comb begin
            o_rs_data[g] = regs[i_rs_sel[g]];
            o_rt_data[g] = regs[i_rt_sel[g]];
            for (int l = 0; l < `LC4_LANES; l++) begin
                if (w_we[l] && (w_sel[l] == i_rs_sel[g])) begin
                    o_rs_data[g] = w_data[l];
                end
                if (w_we[l] && (w_sel[l] == i_rt_sel[g])) begin
                    o_rt_data[g] = w_data[l];
                end
            end
        end
    end

endmodule

/* lc4_superscalar.sv */
`include "lc4_cfg.svh"

module lc4_superscalar (
    input  logic                   gwe,
    input  logic                   i_rst_n,

    output logic [`LC4_WORD-1:0]   o_cur_pc,       // fetch address, pair is pc and pc+1
    input  logic [`LC4_WORD-1:0]   i_cur_insn_a,
    input  logic [`LC4_WORD-1:0]   i_cur_insn_b,

    // retire slot, lane a
    output logic [1:0]             o_test_stall_a,
    output logic [`LC4_WORD-1:0]   o_test_pc_a,
    output logic [`LC4_WORD-1:0]   o_test_insn_a,
    output logic                   o_test_regfile_we_a,
    output logic [`LC4_RSEL_W-1:0] o_test_wsel_a,
    output logic [`LC4_WORD-1:0]   o_test_regfile_data_a,
    output logic                   o_test_nzp_we_a,
    output logic [2:0]             o_test_nzp_a,

    // retire slot, lane b
    output logic [1:0]             o_test_stall_b,
    output logic [`LC4_WORD-1:0]   o_test_pc_b,
    output logic [`LC4_WORD-1:0]   o_test_insn_b,
    output logic                   o_test_regfile_we_b,
    output logic [`LC4_RSEL_W-1:0] o_test_wsel_b,
    output logic [`LC4_WORD-1:0]   o_test_regfile_data_b,
    output logic                   o_test_nzp_we_b,
    output logic [2:0]             o_test_nzp_b
);

    lc4_issue_if  issue_bus  [`LC4_LANES] ();
    lc4_retire_if retire_bus [`LC4_LANES] ();

    logic [`LC4_RSEL_W-1:0] rs_sel  [`LC4_LANES];
    logic [`LC4_RSEL_W-1:0] rt_sel  [`LC4_LANES];
    logic [`LC4_WORD-1:0]   rs_data [`LC4_LANES];
    logic [`LC4_WORD-1:0]   rt_data [`LC4_LANES];

    lc4_issue issue_i (
        .gwe      (gwe),
        .i_rst_n  (i_rst_n),
        .i_insn_a (i_cur_insn_a),
        .i_insn_b (i_cur_insn_b),
        .o_pc     (o_cur_pc),
        .o_issue  (issue_bus)
    );

    for (genvar g = 0; g < `LC4_LANES; g++) begin : g_lane
        lc4_lane lane_i (
            .gwe       (gwe),
            .i_rst_n   (i_rst_n),
            .i_issue   (issue_bus[g]),
            .o_rs_sel  (rs_sel[g]),
            .o_rt_sel  (rt_sel[g]),
            .i_rs_data (rs_data[g]),
            .i_rt_data (rt_data[g]),
            .o_retire  (retire_bus[g])
        );
    end

    lc4_regfile_ss regfile_i (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_retire  (retire_bus),
        .i_rs_sel  (rs_sel),
        .i_rt_sel  (rt_sel),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    assign o_test_stall_a        = retire_bus[0].stall;
    assign o_test_pc_a           = retire_bus[0].pc;
    assign o_test_insn_a         = retire_bus[0].insn;
    assign o_test_regfile_we_a   = retire_bus[0].regfile_we;
    assign o_test_wsel_a         = retire_bus[0].wsel;
    assign o_test_regfile_data_a = retire_bus[0].data;
    assign o_test_nzp_we_a       = retire_bus[0].nzp_we;
    assign o_test_nzp_a          = retire_bus[0].nzp;

    assign o_test_stall_b        = retire_bus[1].stall;
    assign o_test_pc_b           = retire_bus[1].pc;
    assign o_test_insn_b         = retire_bus[1].insn;
    assign o_test_regfile_we_b   = retire_bus[1].regfile_we;
    assign o_test_wsel_b         = retire_bus[1].wsel;
    assign o_test_regfile_data_b = retire_bus[1].data;
    assign o_test_nzp_we_b       = retire_bus[1].nzp_we;
    assign o_test_nzp_b          = retire_bus[1].nzp;

endmodule

/* tb_lc4_superscalar.sv */
`include "lc4_cfg.svh"

module tb_lc4_superscalar
    import lc4_isa_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // one expected or observed retire slot
    typedef struct packed {
        logic [1:0]  stall;
        logic [15:0] pc;
        logic [15:0] insn;
        logic        we;
        logic [2:0]  wsel;
        logic [15:0] data;
        logic        nzp_we;
        logic [2:0]  nzp;
    } slot_t;

    logic                   gwe;
    logic                   i_rst_n;
    logic [`LC4_WORD-1:0]   o_cur_pc;
    logic [`LC4_WORD-1:0]   i_cur_insn_a;
    logic [`LC4_WORD-1:0]   i_cur_insn_b;
    logic [1:0]             o_test_stall_a, o_test_stall_b;
    logic [`LC4_WORD-1:0]   o_test_pc_a, o_test_pc_b;
    logic [`LC4_WORD-1:0]   o_test_insn_a, o_test_insn_b;
    logic                   o_test_regfile_we_a, o_test_regfile_we_b;
    logic [`LC4_RSEL_W-1:0] o_test_wsel_a, o_test_wsel_b;
    logic [`LC4_WORD-1:0]   o_test_regfile_data_a, o_test_regfile_data_b;
    logic                   o_test_nzp_we_a, o_test_nzp_we_b;
    logic [2:0]             o_test_nzp_a, o_test_nzp_b;

    logic [15:0] imem [0:65535];      // instruction memory where 0000 reads as nop
    logic [15:0] model_regs [0:7];    // reference register file
    slot_t       exp_a [$];           // predicted retire slots in order
    slot_t       exp_b [$];
    logic [15:0] pc_seen [$];         // o_cur_pc at each falling edge
    logic [31:0] rng;

    lc4_superscalar dut_i (
        .gwe                   (gwe),
        .i_rst_n               (i_rst_n),
        .o_cur_pc              (o_cur_pc),
        .i_cur_insn_a          (i_cur_insn_a),
        .i_cur_insn_b          (i_cur_insn_b),
        .o_test_stall_a        (o_test_stall_a),
        .o_test_pc_a           (o_test_pc_a),
        .o_test_insn_a         (o_test_insn_a),
        .o_test_regfile_we_a   (o_test_regfile_we_a),
        .o_test_wsel_a         (o_test_wsel_a),
        .o_test_regfile_data_a (o_test_regfile_data_a),
        .o_test_nzp_we_a       (o_test_nzp_we_a),
        .o_test_nzp_a          (o_test_nzp_a),
        .o_test_stall_b        (o_test_stall_b),
        .o_test_pc_b           (o_test_pc_b),
        .o_test_insn_b         (o_test_insn_b),
        .o_test_regfile_we_b   (o_test_regfile_we_b),
        .o_test_wsel_b         (o_test_wsel_b),
        .o_test_regfile_data_b (o_test_regfile_data_b),
        .o_test_nzp_we_b       (o_test_nzp_we_b),
        .o_test_nzp_b          (o_test_nzp_b)
    );

    // fetch answers in the same cycle
    assign i_cur_insn_a = imem[o_cur_pc];
    assign i_cur_insn_b = imem[o_cur_pc + 16'd1];

    initial begin
        gwe = 1'b0;
        forever #20 gwe = ~gwe;       // 40 ns period
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("[ERROR] t=%0t %s: got %h expected %h", $time, name, got, want);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] enc_const(input logic [2:0] rd, input logic [8:0] imm9);
        return {OP_CONST, rd, imm9};
    endfunction

    function automatic logic [15:0] enc_rr(input logic [3:0] opc, input logic [2:0] rd,
                                           input logic [2:0] rs, input logic [1:0] sub,
                                           input logic [2:0] rt);
        return {opc, rd, rs, 1'b0, sub, rt};
    endfunction

    function automatic logic [15:0] enc_ri(input logic [3:0] opc, input logic [2:0] rd,
                                           input logic [2:0] rs, input logic [4:0] imm5);
        return {opc, rd, rs, 1'b1, imm5};
    endfunction

    // kept opcodes write rd except arith r-form sub-op 11 (div)
    function automatic bit writes_reg(input logic [15:0] w);
        if (w[15:12] == OP_CONST || w[15:12] == OP_LOGIC) return 1'b1;
        if (w[15:12] == OP_ARITH) return w[5] || (w[4:3] != 2'b11);
        return 1'b0;
    endfunction

    function automatic bit reads_reg(input logic [15:0] w, input logic [2:0] r);
        bit uses_rt;
        if (!writes_reg(w) || w[15:12] == OP_CONST) return 1'b0;
        uses_rt = !w[5] && !(w[15:12] == OP_LOGIC && w[4:3] == 2'b01);   // not is unary
        return (w[8:6] == r) || (uses_rt && w[2:0] == r);
    endfunction

    function automatic logic [15:0] model_result(input logic [15:0] w);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        a = model_regs[w[8:6]];
        b = w[5] ? {{11{w[4]}}, w[4:0]} : model_regs[w[2:0]];
        if (w[15:12] == OP_CONST) begin
            res = {{7{w[8]}}, w[8:0]};
        end else if (w[15:12] == OP_ARITH) begin
            if (w[5] || w[4:3] == 2'b00) res = a + b;
            else if (w[4:3] == 2'b01) res = a * b;     // low 16 bits
            else res = a - b;
        end else if (w[5] || w[4:3] == 2'b00) begin
            res = a & b;
        end else if (w[4:3] == 2'b01) begin
            res = ~a;
        end else if (w[4:3] == 2'b10) begin
            res = a | b;
        end else begin
            res = a ^ b;
        end
        return res;
    endfunction

    function automatic logic [2:0] nzp_of(input logic [15:0] v);
        if (v == 16'h0) return 3'b010;
        return v[15] ? 3'b100 : 3'b001;
    endfunction

    // runs one word in order and updates the model registers
    function automatic slot_t execute_slot(input logic [15:0] w, input logic [15:0] pc);
        slot_t s;
        s        = '0;
        s.stall  = `LC4_STALL_ISSUED;
        s.pc     = pc;
        s.insn   = w;
        s.we     = writes_reg(w);
        s.nzp_we = s.we;
        s.wsel   = w[11:9];
        s.data   = s.we ? model_result(w) : 16'h0;
        s.nzp    = nzp_of(s.data);
        if (s.we) model_regs[s.wsel] = s.data;
        return s;
    endfunction

    // replays memory from the reset pc with the split rule
    task automatic predict_program(input int n_pairs);
        logic [15:0] p;
        logic [15:0] wa;
        logic [15:0] wb;
        slot_t       bubble;
        exp_a.delete();
        exp_b.delete();
        for (int r = 0; r < 8; r++) begin
            model_regs[r] = 16'h0;
        end
        p = `LC4_RESET_PC;
        for (int j = 0; j < n_pairs; j++) begin
            wa = imem[p];
            wb = imem[p + 16'd1];
            exp_a.push_back(execute_slot(wa, p));
            if (writes_reg(wa) && reads_reg(wb, wa[11:9])) begin
                bubble       = '0;
                bubble.stall = `LC4_STALL_SPLIT;
                bubble.pc    = p + 16'd1;
                exp_b.push_back(bubble);
                p = p + 16'd1;                          // b refetched as next a
            end else begin
                exp_b.push_back(execute_slot(wb, p + 16'd1));
                p = p + 16'd2;
            end
        end
    endtask

    function automatic slot_t sample_lane(input bit lane_b);
        slot_t s;
        s.stall  = lane_b ? o_test_stall_b : o_test_stall_a;
        s.pc     = lane_b ? o_test_pc_b : o_test_pc_a;
        s.insn   = lane_b ? o_test_insn_b : o_test_insn_a;
        s.we     = lane_b ? o_test_regfile_we_b : o_test_regfile_we_a;
        s.wsel   = lane_b ? o_test_wsel_b : o_test_wsel_a;
        s.data   = lane_b ? o_test_regfile_data_b : o_test_regfile_data_a;
        s.nzp_we = lane_b ? o_test_nzp_we_b : o_test_nzp_we_a;
        s.nzp    = lane_b ? o_test_nzp_b : o_test_nzp_a;
        return s;
    endfunction

    task automatic compare_slot(input string lane, input slot_t got, input slot_t want);
        check_value({"o_test_stall_", lane}, got.stall, want.stall);
        check_value({"o_test_pc_", lane}, got.pc, want.pc);
        check_value({"o_test_regfile_we_", lane}, got.we, want.we);
        check_value({"o_test_nzp_we_", lane}, got.nzp_we, want.nzp_we);
        if (want.stall != `LC4_STALL_SPLIT) begin
            check_value({"o_test_insn_", lane}, got.insn, want.insn);
        end
        if (want.we) begin
            check_value({"o_test_wsel_", lane}, got.wsel, want.wsel);
            check_value({"o_test_regfile_data_", lane}, got.data, want.data);
        end
        if (want.nzp_we) check_value({"o_test_nzp_", lane}, got.nzp, want.nzp);
    endtask

    // nothing has retired yet
    task automatic check_idle_outputs(input bit with_pc);
        if (with_pc) check_value("o_cur_pc", o_cur_pc, `LC4_RESET_PC);
        check_value("o_test_regfile_we_a", o_test_regfile_we_a, 0);
        check_value("o_test_regfile_we_b", o_test_regfile_we_b, 0);
        check_value("o_test_nzp_we_a", o_test_nzp_we_a, 0);
        check_value("o_test_nzp_we_b", o_test_nzp_we_b, 0);
        check_value("o_test_stall_a", o_test_stall_a, `LC4_STALL_RESET);
        check_value("o_test_stall_b", o_test_stall_b, `LC4_STALL_RESET);
    endtask

    // 16 edges with reset low and release driven on the last one
    task automatic apply_reset(input bit check_outputs);
        @(posedge gwe);
        i_rst_n <= 1'b0;
        for (int c = 0; c < 15; c++) begin
            @(posedge gwe);
            @(negedge gwe);
            if (check_outputs) check_idle_outputs(1'b1);
        end
        @(posedge gwe);
        i_rst_n <= 1'b1;
    endtask

    task automatic wait_retire_pair();
        int waited;
        waited = 0;
        do begin
            @(negedge gwe);
            pc_seen.push_back(o_cur_pc);
            waited++;
        end while (o_test_stall_a == `LC4_STALL_RESET && waited < 8);
        if (o_test_stall_a == `LC4_STALL_RESET) begin
            $display("ERROR: no pair retired within %0d cycles at t=%0t", waited, $time);
            $display("TEST RESULT: FAIL");
            $fatal(1, "retire timeout");
        end
    endtask

    task automatic clear_memory();
        for (int a = 0; a < 65536; a++) begin
            imem[a] = 16'h0000;
        end
    endtask

    // resets the DUT and checks n_pairs retire slots against the model
    task automatic run_program(input int n_pairs);
        int          k;
        logic [15:0] step;
        logic [15:0] diff;
        predict_program(n_pairs);
        apply_reset(1'b0);
        pc_seen.delete();
        for (int j = 0; j < n_pairs; j++) begin
            wait_retire_pair();
            k = pc_seen.size();
            check_value("retire latency of first pair", k >= 3, 1);
            step = (exp_b[j].stall == `LC4_STALL_SPLIT) ? 16'd1 : 16'd2;
            diff = pc_seen[k-2] - pc_seen[k-3];
            check_value("o_cur_pc two edges before retire", pc_seen[k-3], exp_a[j].pc);
            check_value("o_cur_pc step", diff, step);
            compare_slot("a", sample_lane(1'b0), exp_a[j]);
            compare_slot("b", sample_lane(1'b1), exp_b[j]);
        end
    endtask

    task automatic test_reset();
        clear_memory();
        imem[16'h8200] = enc_const(3'd1, 9'd1);
        imem[16'h8201] = enc_const(3'd2, 9'd2);
        apply_reset(1'b1);
        pc_seen.delete();
        for (int i = 0; i < 2; i++) begin       // issue and w stages still filling
            @(negedge gwe);
            pc_seen.push_back(o_cur_pc);
            check_idle_outputs(1'b0);
        end
        check_value("o_cur_pc after release", pc_seen[0], `LC4_RESET_PC);
        wait_retire_pair();
        check_value("o_test_pc_a", o_test_pc_a, `LC4_RESET_PC);
        check_value("o_test_stall_a", o_test_stall_a, `LC4_STALL_ISSUED);
    endtask

    task automatic test_independent_pairs();
        clear_memory();
        imem[16'h8200] = enc_const(3'd0, 9'd37);
        imem[16'h8201] = enc_const(3'd1, 9'h1FF);     // -1
        imem[16'h8202] = enc_const(3'd2, 9'd0);
        imem[16'h8203] = enc_const(3'd3, 9'd255);
        imem[16'h8204] = enc_const(3'd4, 9'h100);     // most negative
        imem[16'h8205] = enc_const(3'd5, 9'd1);
        imem[16'h8206] = enc_const(3'd6, 9'h155);
        imem[16'h8207] = enc_const(3'd7, 9'h0AA);
        run_program(6);
    endtask

    task automatic test_split();
        clear_memory();
        imem[16'h8200] = enc_const(3'd1, 9'd5);
        imem[16'h8201] = enc_rr(OP_ARITH, 3'd2, 3'd1, 2'b00, 3'd1);   // reads r1 so it splits
        imem[16'h8202] = enc_ri(OP_LOGIC, 3'd3, 3'd2, 5'd7);          // reads r2 so it splits
        imem[16'h8203] = enc_const(3'd5, 9'h1FD);
        imem[16'h8204] = enc_const(3'd6, 9'd1);
        imem[16'h8205] = enc_const(3'd6, 9'd2);                        // same rd and no read
        imem[16'h8206] = enc_const(3'd7, 9'd9);
        imem[16'h8207] = enc_rr(OP_LOGIC, 3'd0, 3'd1, 2'b01, 3'd7);   // not ignores rt
        imem[16'h8208] = enc_rr(OP_ARITH, 3'd4, 3'd6, 2'b10, 3'd7);
        imem[16'h8209] = enc_rr(OP_ARITH, 3'd1, 3'd4, 2'b00, 3'd0);   // reads r4 so it splits
        run_program(8);
    endtask

    task automatic test_forwarding();
        clear_memory();
        imem[16'h8200] = enc_const(3'd1, 9'd3);
        imem[16'h8201] = enc_const(3'd2, 9'd4);
        imem[16'h8202] = enc_rr(OP_ARITH, 3'd3, 3'd1, 2'b00, 3'd2);   // a reads last b
        imem[16'h8203] = enc_rr(OP_ARITH, 3'd4, 3'd1, 2'b10, 3'd2);   // b reads last a
        imem[16'h8204] = enc_rr(OP_ARITH, 3'd5, 3'd4, 2'b01, 3'd3);
        imem[16'h8205] = enc_rr(OP_ARITH, 3'd6, 3'd3, 2'b00, 3'd4);
        imem[16'h8206] = enc_rr(OP_LOGIC, 3'd1, 3'd6, 2'b11, 3'd5);
        imem[16'h8207] = enc_rr(OP_LOGIC, 3'd2, 3'd5, 2'b10, 3'd6);
        imem[16'h8208] = enc_ri(OP_ARITH, 3'd7, 3'd2, 5'h1B);         // -5
        imem[16'h8209] = enc_rr(OP_ARITH, 3'd0, 3'd1, 2'b10, 3'd2);
        imem[16'h820A] = enc_ri(OP_LOGIC, 3'd3, 3'd7, 5'h0F);
        imem[16'h820B] = enc_rr(OP_LOGIC, 3'd4, 3'd0, 2'b01, 3'd0);
        run_program(8);
    endtask

    function automatic logic [15:0] random_insn(input logic [31:0] r);
        logic [2:0] rd;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [3:0] kind;
        rd   = {1'b0, r[4:3]};          // few targets give more same-rd pairs and splits
        rs   = r[8:6];
        rt   = r[11:9];
        kind = r[31:28] % 4'd7;
        case (kind)
            4'd0, 4'd1: return enc_const(rd, r[24:16]);
            4'd2:       return enc_rr(OP_ARITH, rd, rs, r[13:12], rt);
            4'd3:       return enc_ri(OP_ARITH, rd, rs, r[18:14]);
            4'd4:       return enc_rr(OP_LOGIC, rd, rs, r[13:12], rt);
            4'd5:       return enc_ri(OP_LOGIC, rd, rs, r[18:14]);
            default:    return {(r[27] ? 4'b1100 : 4'b0000), r[11:0]};   // unsupported
        endcase
    endfunction

    task automatic test_mixed_random();
        clear_memory();
        imem[16'h8200] = enc_const(3'd3, 9'd11);
        imem[16'h8201] = enc_const(3'd3, 9'd22);                // both lanes write r3
        imem[16'h8202] = enc_ri(OP_ARITH, 3'd4, 3'd3, 5'd0);    // should see 22
        for (int i = 0; i < 48; i++) begin
            rng = xorshift32(rng);
            imem[16'h8203 + i] = random_insn(rng);
        end
        run_program(40);
    endtask

    initial begin
        i_rst_n = 1'b0;
        rng     = 32'd455;
        clear_memory();
        test_reset();
        test_independent_pairs();
        test_split();
        test_forwarding();
        test_mixed_random();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
lc4_isa_pkg.sv
lc4_pipe_pkg.sv
lc4_ifaces.sv
lc4_decoder.sv
lc4_issue.sv
lc4_lane.sv
lc4_regfile_ss.sv
lc4_superscalar.sv
tb_lc4_superscalar.sv
